// File: Bender.yml
package:
  name: eth_buffer_mac

sources:
  - logic/eth_mac_pkg.sv
  - logic/packet_ring_ram.sv
  - logic/host_port.sv
  - logic/tx_framer.sv
  - logic/rx_deframer.sv
  - logic/eth_buffer_mac.sv
  - target: test
    files:
      - tb/eth_buffer_mac_assert.sv
      - tb/eth_buffer_mac_tb.sv

// File: logic/eth_buffer_mac.sv
`timescale 1ns/1ps

module eth_buffer_mac import eth_mac_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      start,
    input  host_req_t req,
    output logic      done,
    output byte_t     result,
    output gmii_t     gmii_tx,
    input  gmii_t     gmii_rx
);

    // transmit side
    ram_write_t tx_wr;
    len_write_t tx_len_wr;
    slot_t      last_wrote;
    slot_t      last_sent;
    slot_t      tx_rd_slot;
    addr_t      tx_rd_addr;
    byte_t      tx_rd_data;
    len_t       tx_len;

    // receive side
    ram_write_t rx_wr;
    len_write_t rx_len_wr;
    addr_t      rx_rd_addr;
    byte_t      rx_rd_data;
    len_t       rx_cur_len;
    slot_t      last_read;
    slot_t      last_recv;

    host_port host (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .req        (req),
        .done       (done),
        .result     (result),
        .tx_wr      (tx_wr),
        .tx_len_wr  (tx_len_wr),
        .last_wrote (last_wrote),
        .last_sent  (last_sent),
        .rx_rd_addr (rx_rd_addr),
        .rx_rd_data (rx_rd_data),
        .rx_cur_len (rx_cur_len),
        .last_read  (last_read),
        .last_recv  (last_recv)
    );

    packet_ring_ram tx_ring (
        .clock    (clock),
        .reset    (reset),
        .wr       (tx_wr),
        .len_wr   (tx_len_wr),
        .rd_slot  (tx_rd_slot),
        .rd_addr  (tx_rd_addr),
        .rd_data  (tx_rd_data),
        .len_slot (tx_rd_slot),
        .len_out  (tx_len)
    );

    tx_framer framer (
        .clock      (clock),
        .reset      (reset),
        .last_wrote (last_wrote),
        .last_sent  (last_sent),
        .rd_slot    (tx_rd_slot),
        .rd_addr    (tx_rd_addr),
        .rd_data    (tx_rd_data),
        .len_out    (tx_len),
        .tx         (gmii_tx)
    );

    // host reads the current packet, slot last_read
    packet_ring_ram rx_ring (
        .clock    (clock),
        .reset    (reset),
        .wr       (rx_wr),
        .len_wr   (rx_len_wr),
        .rd_slot  (last_read),
        .rd_addr  (rx_rd_addr),
        .rd_data  (rx_rd_data),
        .len_slot (last_read),
        .len_out  (rx_cur_len)
    );

    rx_deframer deframer (
        .clock     (clock),
        .reset     (reset),
        .rx        (gmii_rx),
        .last_read (last_read),
        .last_recv (last_recv),
        .wr        (rx_wr),
        .len_wr    (rx_len_wr)
    );

endmodule

// File: logic/eth_mac_pkg.sv
package eth_mac_pkg;

    localparam int ring_slots = 4;    // packets per ring
    localparam int slot_bytes = 64;   // bytes per packet slot
    localparam int ifg_cycles = 12;

    localparam logic [7:0]  preamble_byte = 8'h55;
    localparam logic [7:0]  sfd_byte      = 8'hd5;
    localparam logic [31:0] crc_residue   = 32'hc704dd7b;  // good-frame residue, msb-first form

    typedef logic [7:0] byte_t;
    typedef logic [1:0] slot_t;
    typedef logic [6:0] len_t;
    typedef logic [5:0] addr_t;

    typedef enum logic [2:0] {
        op_read       = 3'd0,
        op_read_len   = 3'd1,
        op_read_next  = 3'd2,
        op_write      = 3'd3,
        op_write_len  = 3'd4,
        op_write_next = 3'd5
    } host_op_t;

    // addr is one bit wider than a slot index so that writes past the end can be refused
    typedef struct packed {
        host_op_t op;
        len_t     addr;
        byte_t    value;
    } host_req_t;

    typedef struct packed {
        logic  en;
        slot_t slot;
        addr_t addr;
        byte_t data;
    } ram_write_t;

    typedef struct packed {
        logic  en;
        slot_t slot;
        len_t  len;
    } len_write_t;

    typedef struct packed {
        byte_t data;
        logic  en;
        logic  er;
    } gmii_t;

    // reflected crc32, lsb of each byte first
    function automatic logic [31:0] next_crc32_d8(input byte_t data, input logic [31:0] crc);
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
        end
        return c;
    endfunction

    function automatic byte_t reverse_byte(input byte_t b);
        byte_t r;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[7 - i];
        end
        return r;
    endfunction

endpackage

// File: logic/host_port.sv
`timescale 1ns/1ps

module host_port import eth_mac_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       start,
    input  host_req_t  req,
    output logic       done,
    output byte_t      result,
    output ram_write_t tx_wr,
    output len_write_t tx_len_wr,
    output slot_t      last_wrote,
    input  slot_t      last_sent,
    output addr_t      rx_rd_addr,
    input  byte_t      rx_rd_data,
    input  len_t       rx_cur_len,
    output slot_t      last_read,
    input  slot_t      last_recv
);

    logic      op_valid;
    host_req_t op_req;
    len_t      fill_len;    // mirrors the ring length of the fill slot
    slot_t     fill_slot;
    logic      addr_ok;
    len_t      grown_len;
    logic      tx_full;
    byte_t     result_d;

    // rx byte fetch starts in the start cycle
    assign rx_rd_addr = addr_t'(req.addr);

    assign fill_slot = slot_t'(last_wrote + 2'd1);
    assign addr_ok   = op_req.addr < len_t'(slot_bytes);
    assign grown_len = (op_req.addr >= fill_len) ? len_t'(op_req.addr + 7'd1) : fill_len;
    assign tx_full   = slot_t'(last_wrote + 2'd2) == last_sent;

    // ----------------------------------------------------------------------
    // second cycle: ring writes and result
    // ----------------------------------------------------------------------
    always_comb begin
        tx_wr     = '0;
        tx_len_wr = '0;
        result_d  = '0;
        case (op_req.op)
            op_read: begin
                if (op_req.addr < rx_cur_len) begin
                    result_d = rx_rd_data;
                end
            end
            op_read_len: result_d = {1'b0, rx_cur_len};
            op_read_next: result_d = {7'd0, last_read == last_recv};  // 1 = nothing left
            op_write: begin
                if (addr_ok) begin
                    tx_wr     = '{en: op_valid, slot: fill_slot,
                                  addr: addr_t'(op_req.addr), data: op_req.value};
                    tx_len_wr = '{en: op_valid, slot: fill_slot, len: grown_len};
                end else begin
                    result_d = 8'd1;   // packet full
                end
            end
            op_write_len: result_d = {1'b0, fill_len};
            op_write_next: begin
                if (tx_full) begin
                    result_d = 8'd1;
                end else begin
                    // new fill slot starts empty
                    tx_len_wr = '{en: op_valid, slot: slot_t'(fill_slot + 2'd1), len: '0};
                end
            end
            default: result_d = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        op_req <= req;
        if (op_valid) begin
            result <= result_d;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            op_valid   <= 1'b0;
            done       <= 1'b0;
            last_wrote <= '0;
            last_read  <= '0;
            fill_len   <= '0;
        end else begin
            op_valid <= start;
            done     <= op_valid;
            if (op_valid) begin
                case (op_req.op)
                    op_write: begin
                        if (addr_ok) begin
                            fill_len <= grown_len;
                        end
                    end
                    op_write_next: begin
                        if (!tx_full) begin
                            last_wrote <= fill_slot;
                            fill_len   <= '0;
                        end
                    end
                    op_read_next: begin
                        if (last_read != last_recv) begin
                            last_read <= slot_t'(last_read + 2'd1);
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: logic/packet_ring_ram.sv
`timescale 1ns/1ps

module packet_ring_ram import eth_mac_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  ram_write_t wr,
    input  len_write_t len_wr,
    input  slot_t      rd_slot,
    input  addr_t      rd_addr,
    output byte_t      rd_data,
    input  slot_t      len_slot,
    output len_t       len_out
);

    byte_t mem [ring_slots * slot_bytes];   // slot-major byte array
    len_t  lens [ring_slots];

    // ----------------------------------------------------------------------
    // byte storage, one cycle read latency
    // ----------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (wr.en) begin
            mem[{wr.slot, wr.addr}] <= wr.data;
        end
        rd_data <= mem[{rd_slot, rd_addr}];
    end

    // ----------------------------------------------------------------------
    // per-slot lengths
    // ----------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ring_slots; i++) begin
                lens[i] <= '0;
            end
        end else if (len_wr.en) begin
            lens[len_wr.slot] <= len_wr.len;
        end
    end

    assign len_out = lens[len_slot];  // no latency on lengths

endmodule

// File: logic/rx_deframer.sv
`timescale 1ns/1ps

module rx_deframer import eth_mac_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  gmii_t      rx,
    input  slot_t      last_read,
    output slot_t      last_recv,
    output ram_write_t wr,
    output len_write_t len_wr
);

    typedef enum logic [1:0] {
        st_hunt,
        st_preamble,
        st_data,
        st_drop
    } rx_state_t;

    rx_state_t   state;
    gmii_t       rx_q;
    logic [2:0]  pre_cnt;
    len_t        count;     // bytes after sfd, fcs included
    logic [31:0] crc;
    logic        bad;       // rx_er seen or slot overflow
    slot_t       tgt_slot;
    logic        room;
    logic        crc_ok;
    logic        commit;

    assign tgt_slot = slot_t'(last_recv + 2'd1);
    assign room     = count < len_t'(slot_bytes);

    // register is reflected, residue constant is not
    assign crc_ok = {reverse_byte(crc[7:0]), reverse_byte(crc[15:8]),
                     reverse_byte(crc[23:16]), reverse_byte(crc[31:24])} == crc_residue;

    // frame ends on the first idle cycle after data
    assign commit = state == st_data && !rx_q.en && crc_ok && !bad
                    && count >= 7'd4 && tgt_slot != last_read;

    assign wr = '{en: state == st_data && rx_q.en && room && tgt_slot != last_read,
                  slot: tgt_slot, addr: addr_t'(count), data: rx_q.data};

    assign len_wr = '{en: commit, slot: tgt_slot, len: len_t'(count - 7'd4)};

    always_ff @(posedge clock) begin
        if (reset) begin
            rx_q      <= '0;
            state     <= st_hunt;
            last_recv <= '0;
        end else begin
            rx_q <= rx;
            case (state)
                st_hunt: begin
                    pre_cnt <= 3'd1;
                    if (rx_q.en) begin
                        if (rx_q.data == preamble_byte && !rx_q.er) begin
                            state <= st_preamble;
                        end else begin
                            state <= st_drop;
                        end
                    end
                end
                st_preamble: begin
                    count <= '0;
                    crc   <= '1;
                    bad   <= 1'b0;
                    if (!rx_q.en) begin
                        state <= st_hunt;
                    end else if (rx_q.er) begin
                        state <= st_drop;
                    end else if (rx_q.data == preamble_byte) begin
                        if (pre_cnt != 3'd7) begin
                            pre_cnt <= pre_cnt + 3'd1;
                        end
                    end else if (rx_q.data == sfd_byte && pre_cnt == 3'd7) begin
                        state <= st_data;
                    end else begin
                        state <= st_drop;
                    end
                end
                st_data: begin
                    if (rx_q.en) begin
                        crc <= next_crc32_d8(rx_q.data, crc);
                        bad <= bad | rx_q.er | !room;
                        if (room) begin
                            count <= count + 7'd1;
                        end
                    end else begin
                        if (commit) begin
                            last_recv <= tgt_slot;
                        end
                        state <= st_hunt;
                    end
                end
                st_drop: begin
                    if (!rx_q.en) begin
                        state <= st_hunt;   // wait out the rest of the frame
                    end
                end
                default: state <= st_hunt;
            endcase
        end
    end

endmodule

// File: logic/tx_framer.sv
`timescale 1ns/1ps

module tx_framer import eth_mac_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  slot_t last_wrote,
    output slot_t last_sent,
    output slot_t rd_slot,
    output addr_t rd_addr,
    input  byte_t rd_data,
    input  len_t  len_out,
    output gmii_t tx
);

    typedef enum logic [2:0] {
        st_ready,
        st_preamble,
        st_sfd,
        st_data,
        st_fcs,
        st_gap
    } tx_state_t;

    tx_state_t   state;
    logic [3:0]  cnt;       // preamble, fcs and gap counter
    addr_t       rd_ptr;    // one byte ahead of the wire
    len_t        sent;
    logic [31:0] crc;

    assign rd_slot = slot_t'(last_sent + 2'd1);   // next committed packet
    assign rd_addr = rd_ptr;

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= st_ready;
            cnt       <= '0;
            rd_ptr    <= '0;
            sent      <= '0;
            last_sent <= '0;
            tx        <= '0;
        end else begin
            case (state)
                st_ready: begin
                    rd_ptr <= '0;
                    sent   <= '0;
                    cnt    <= '0;
                    crc    <= '1;
                    if (last_sent != last_wrote) begin
                        tx    <= '{data: preamble_byte, en: 1'b1, er: 1'b0};
                        state <= st_preamble;
                    end
                end
                st_preamble: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd6) begin
                        tx.data <= sfd_byte;
                        rd_ptr  <= addr_t'(1);   // byte 0 already fetched
                        state   <= st_sfd;
                    end
                end
                st_sfd, st_data: begin
                    if (sent < len_out) begin
                        tx.data <= rd_data;
                        crc     <= next_crc32_d8(rd_data, crc);
                        sent    <= sent + 7'd1;
                        rd_ptr  <= rd_ptr + 6'd1;
                        state   <= st_data;
                    end else begin
                        tx.data <= ~crc[7:0];   // fcs, low byte first
                        crc     <= crc >> 8;
                        cnt     <= '0;
                        state   <= st_fcs;
                    end
                end
                st_fcs: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd3) begin
                        tx.en     <= 1'b0;
                        last_sent <= rd_slot;
                        cnt       <= '0;
                        state     <= st_gap;
                    end else begin
                        tx.data <= ~crc[7:0];
                        crc     <= crc >> 8;
                    end
                end
                st_gap: begin
                    cnt <= cnt + 4'd1;
                    // ready adds the last idle cycle
                    if (cnt == 4'(ifg_cycles - 2)) begin
                        state <= st_ready;
                    end
                end
                default: state <= st_ready;
            endcase
        end
    end

endmodule

// File: src.f
logic/eth_mac_pkg.sv
logic/packet_ring_ram.sv
logic/host_port.sv
logic/tx_framer.sv
logic/rx_deframer.sv
logic/eth_buffer_mac.sv
tb/eth_buffer_mac_assert.sv
tb/eth_buffer_mac_tb.sv

// File: tb/eth_buffer_mac_assert.sv
`timescale 1ns/1ps

module eth_buffer_mac_assert import eth_mac_pkg::*; (
    input logic  clock,
    input logic  reset,
    input logic  start,
    input logic  done,
    input gmii_t gmii_tx
);

    // host handshake
    done_latency: assert property (@(posedge clock) disable iff (reset) start |-> ##2 done)
        else $error("done did not follow start by exactly two cycles");

    start_while_pending: assert property (@(posedge clock) disable iff (reset)
        start |=> !start [*2])
        else $error("start pulsed while an operation was pending");

    // transmitter quiet once reset has been sampled
    tx_quiet_in_reset: assert property (@(posedge clock) reset |=> !gmii_tx.en)
        else $error("tx_en high during reset");

endmodule

bind eth_buffer_mac eth_buffer_mac_assert checks (
    .clock   (clock),
    .reset   (reset),
    .start   (start),
    .done    (done),
    .gmii_tx (gmii_tx)
);

// File: tb/eth_buffer_mac_tb.sv
`timescale 1ns/1ps

module eth_buffer_mac_tb import eth_mac_pkg::*; ();

    logic      clock;
    logic      reset;
    logic      start;
    host_req_t req;
    logic      done;
    byte_t     result;
    gmii_t     gmii_tx;
    gmii_t     gmii_rx;

    byte_t       stim [0:511];
    logic [31:0] lfsr_state = 32'd69392;

    eth_buffer_mac dut0 (
        .clock   (clock),
        .reset   (reset),
        .start   (start),
        .req     (req),
        .done    (done),
        .result  (result),
        .gmii_tx (gmii_tx),
        .gmii_rx (gmii_rx)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_stall(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic run_op(input host_op_t op, input len_t addr, input byte_t value,
                          output byte_t res);
        int waited;
        @(negedge clock);
        req   = '{op: op, addr: addr, value: value};
        start = 1'b1;
        @(negedge clock);
        start  = 1'b0;
        waited = 0;
        while (!done) begin
            if (waited == 10) begin
                report_stall("host operation never signalled done");
            end else begin
                @(negedge clock);
                waited++;
            end
        end
        res = result;
    endtask

    task automatic expect_op(input string name, input host_op_t op, input len_t addr,
                             input byte_t value, input int expected);
        byte_t res;
        run_op(op, addr, value, res);
        check_value(name, expected, res);
    endtask

    // ----------------------------------------------------------------------
    // transmit: fill, commit, watch the wire
    // ----------------------------------------------------------------------
    task automatic test_transmit(input int base, input int len);
        byte_t exp_bytes [0:127];
        byte_t cap [0:127];
        int    n;
        int    waited;
        for (int i = 0; i < len; i++) begin
            expect_op($sformatf("tx write %0d", i), op_write, len_t'(i), stim[base + i], 0);
        end
        expect_op("tx write_len", op_write_len, '0, '0, len);
        expect_op("tx write_next", op_write_next, '0, '0, 0);
        for (int i = 0; i < 7; i++) exp_bytes[i] = 8'h55;
        exp_bytes[7] = 8'hd5;
        for (int i = 0; i < len + 4; i++) exp_bytes[8 + i] = stim[base + i];
        waited = 0;
        while (!gmii_tx.en) begin
            if (waited == 3) begin
                report_stall("transmit frame did not start within 3 cycles of the commit");
            end else begin
                @(negedge clock);
                waited++;
            end
        end
        n = 0;
        while (gmii_tx.en && n < 128) begin
            cap[n] = gmii_tx.data;
            check_value("tx_er in frame", 0, gmii_tx.er);
            n++;
            @(negedge clock);
        end
        check_value("tx frame cycles", len + 12, n);
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("tx byte %0d", i), exp_bytes[i], cap[i]);
        end
        for (int i = 0; i < 12; i++) begin
            check_value($sformatf("tx gap cycle %0d", i), 0, gmii_tx.en);
            @(negedge clock);
        end
    endtask

    // ----------------------------------------------------------------------
    // receive
    // ----------------------------------------------------------------------
    task automatic send_rx_frame(input int base, input int len, input bit with_er);
        int gap;
        for (int i = 0; i < len + 8; i++) begin
            @(negedge clock);
            gmii_rx.en = 1'b1;
            gmii_rx.er = with_er && i == 9;
            if (i < 7) gmii_rx.data = 8'h55;
            else if (i == 7) gmii_rx.data = 8'hd5;
            else gmii_rx.data = stim[base + i - 8];
        end
        @(negedge clock);
        gmii_rx = '0;
        random_bits(4, gap);
        repeat (gap + 4) @(negedge clock);
    endtask

    task automatic test_good_receive(input int base, input int len);
        send_rx_frame(base, len, 1'b0);
        expect_op("rx read_next", op_read_next, '0, '0, 0);
        expect_op("rx read_len", op_read_len, '0, '0, len - 4);
        for (int i = 0; i < len - 4; i++) begin
            expect_op($sformatf("rx read %0d", i), op_read, len_t'(i), '0, stim[base + i]);
        end
        expect_op("rx read past end", op_read, len_t'(len - 4), '0, 0);
        expect_op("rx read_next empty", op_read_next, '0, '0, 1);
    endtask

    task automatic test_bad_receive(input int base, input int len, input bit with_er);
        send_rx_frame(base, len, with_er);
        expect_op(with_er ? "rx_er frame dropped" : "bad fcs dropped",
                  op_read_next, '0, '0, 1);
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        int kind;
        int len;
        int pos;
        int quiet;
        int waited;
        reset   = 1'b1;
        start   = 1'b0;
        req     = '0;
        gmii_rx = '0;
        for (int i = 0; i < 512; i++) stim[i] = '0;
        $readmemh("tb/frames_input.txt", stim);

        repeat (10) begin
            @(negedge clock);
            check_value("tx_en in reset", 0, gmii_tx.en === 1'b1);
        end
        reset = 1'b0;

        expect_op("reset write_len", op_write_len, '0, '0, 0);
        expect_op("reset read_next", op_read_next, '0, '0, 1);
        check_value("tx_en after reset", 0, gmii_tx.en);

        pos = 0;
        while (stim[pos] != 0 && pos < 480) begin
            kind = stim[pos];
            len  = stim[pos + 1];
            case (kind)
                1: test_transmit(pos + 2, len);
                2: test_good_receive(pos + 2, len);
                3: test_bad_receive(pos + 2, len, 1'b0);
                4: test_bad_receive(pos + 2, len, 1'b1);
                default: report_stall("unknown record kind in stimulus file");
            endcase
            pos += 2 + len + (kind == 1 ? 4 : 0);
        end

        // limits, two committed packets fill the ring
        expect_op("write past slot", op_write, len_t'(64), 8'haa, 1);
        expect_op("commit 1", op_write_next, '0, '0, 0);
        expect_op("commit 2", op_write_next, '0, '0, 0);
        expect_op("commit ring full", op_write_next, '0, '0, 1);

        quiet  = 0;
        waited = 0;
        while (quiet < 20) begin
            if (waited == 500) begin
                report_stall("transmitter did not drain the ring");
            end else begin
                @(negedge clock);
                quiet = gmii_tx.en ? 0 : quiet + 1;
                waited++;
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: tb/frames_input.txt
// kind: 01 tx packet, 02 rx good, 03 rx bad fcs, 04 rx with rx_er
// then byte count, then bytes (tx: data, then expected fcs; rx: data with fcs)
01 09
31 32 33 34 35 36 37 38 39
26 39 f4 cb
01 2b
54 68 65 20 71 75 69 63 6b 20 62 72 6f 77 6e 20
66 6f 78 20 6a 75 6d 70 73 20 6f 76 65 72 20 74
68 65 20 6c 61 7a 79 20 64 6f 67
39 a3 4f 41
02 0d
31 32 33 34 35 36 37 38 39 26 39 f4 cb
03 07
61 62 63 c2 41 24 36
04 07
61 62 63 c2 41 24 35
02 07
61 62 63 c2 41 24 35
00
